/* design/axi_mem_cfg.svh */
`ifndef AXI_MEM_CFG_SVH
`define AXI_MEM_CFG_SVH

`define ADDR_WIDTH 12 // byte address
`define DATA_WIDTH 32
`define STRB_WIDTH (`DATA_WIDTH / 8)
`define ID_BITS 4
`define LEN_BITS 4 // a burst has len + 1 beats
`define SIZE_BITS 3

// the RAM covers the whole byte address space
`define MEM_WORDS 1024
`define WADDR_WIDTH ($clog2(`MEM_WORDS))
`define BYTE_OFF_BITS ($clog2(`STRB_WIDTH))

`endif

/* design/axi_mem_pkg.sv */
`include "axi_mem_cfg.svh"

package axi_mem_pkg;

  // burst encodings as they appear on awburst and arburst
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

  typedef logic [`LEN_BITS-1:0] beat_cnt_t; // beat index within one burst

endpackage

/* design/mem_port_if.sv */
`timescale 1ns/10ps
`include "axi_mem_cfg.svh"

// one requester port of the shared RAM
interface mem_port_if;
  logic                     req;
  logic                     we;
  logic [`WADDR_WIDTH-1:0]  addr; // word address
  logic [`DATA_WIDTH-1:0]   wdata;
  logic [`STRB_WIDTH-1:0]   strb;
  logic                     gnt;  // same cycle as req
  logic [`DATA_WIDTH-1:0]   rdata; // one cycle after a granted read

  modport requester (
    output req, we, addr, wdata, strb,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata, strb,
    output gnt, rdata
  );
endinterface

/* design/axi_write_engine.sv */
`timescale 1ns/10ps
`include "axi_mem_cfg.svh"

module axi_write_engine (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`ID_BITS-1:0]      awid_i,
  input  logic [`ADDR_WIDTH-1:0]   awaddr_i,
  input  logic [`LEN_BITS-1:0]     awlen_i,
  input  logic [`SIZE_BITS-1:0]    awsize_i,
  input  axi_mem_pkg::axi_burst_t  awburst_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [`DATA_WIDTH-1:0]   wdata_i,
  input  logic [`STRB_WIDTH-1:0]   wstrb_i,
  input  logic                     wlast_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  output logic [`ID_BITS-1:0]      bid_o,
  output axi_mem_pkg::axi_resp_t   bresp_o,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  mem_port_if.requester            mem
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {S_ADDR, S_DATA, S_RESP} state_t;

  localparam logic [`ADDR_WIDTH-1:0] ADDR_ONE = 1;

  state_t                   state_q;
  logic [`ID_BITS-1:0]      id_q;
  logic [`ADDR_WIDTH-1:0]   addr_q;
  logic [`SIZE_BITS-1:0]    size_q;
  axi_burst_t               burst_q;
  beat_cnt_t                len_q;
  beat_cnt_t                beat_q;
  logic                     len_err_q;
  axi_resp_t                resp_q;
  logic                     is_wrap;
  logic                     w_fire;
  logic                     last_err;

  assign is_wrap   = (burst_q == WRAP);
  assign awready_o = (state_q == S_ADDR);

  // a WRAP burst drains its data without touching the RAM
  assign mem.req   = (state_q == S_DATA) && wvalid_i && !is_wrap;
  assign mem.we    = 1'b1;
  assign mem.addr  = addr_q[`ADDR_WIDTH-1:`BYTE_OFF_BITS];
  assign mem.wdata = wdata_i;
  assign mem.strb  = wstrb_i;

  assign wready_o = (state_q == S_DATA) && (is_wrap ? wvalid_i : mem.gnt);
  assign w_fire   = wvalid_i && wready_o;
  assign last_err = wlast_i != (beat_q == len_q); // wlast out of step with awlen

  assign bvalid_o = (state_q == S_RESP);
  assign bid_o    = id_q;
  assign bresp_o  = resp_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_ADDR;
    end else begin
      case (state_q)
        S_ADDR: begin
          if (awvalid_i) begin
            state_q <= S_DATA;
          end
        end
        S_DATA: begin
          if (w_fire && wlast_i) begin
            state_q <= S_RESP;
          end
        end
        S_RESP: begin
          if (bready_i) begin
            state_q <= S_ADDR;
          end
        end
        default: state_q <= S_ADDR;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (awvalid_i && awready_o) begin
      id_q      <= awid_i;
      addr_q    <= awaddr_i;
      size_q    <= awsize_i;
      burst_q   <= awburst_i;
      len_q     <= awlen_i;
      beat_q    <= '0;
      len_err_q <= 1'b0;
    end else if (w_fire) begin
      beat_q    <= beat_q + 1'b1;
      len_err_q <= len_err_q | last_err;
      if (burst_q != FIXED) begin
        addr_q <= addr_q + (ADDR_ONE << size_q); // step is 2**size bytes
      end
      if (wlast_i) begin
        resp_q <= (is_wrap || len_err_q || last_err) ? SLVERR : OKAY;
      end
    end
  end

endmodule

/* design/axi_read_engine.sv */
`timescale 1ns/10ps
`include "axi_mem_cfg.svh"

module axi_read_engine (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`ID_BITS-1:0]      arid_i,
  input  logic [`ADDR_WIDTH-1:0]   araddr_i,
  input  logic [`LEN_BITS-1:0]     arlen_i,
  input  logic [`SIZE_BITS-1:0]    arsize_i,
  input  axi_mem_pkg::axi_burst_t  arburst_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  output logic [`ID_BITS-1:0]      rid_o,
  output logic [`DATA_WIDTH-1:0]   rdata_o,
  output axi_mem_pkg::axi_resp_t   rresp_o,
  output logic                     rlast_o,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  mem_port_if.requester            mem
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {S_ADDR, S_DATA, S_DRAIN} state_t;

  localparam logic [`ADDR_WIDTH-1:0] ADDR_ONE = 1;

  state_t                   state_q;
  logic [`ID_BITS-1:0]      id_q;
  logic [`ADDR_WIDTH-1:0]   addr_q;
  logic [`SIZE_BITS-1:0]    size_q;
  axi_burst_t               burst_q;
  beat_cnt_t                len_q;
  beat_cnt_t                req_cnt_q; // beats issued so far
  logic                     rvalid_q;
  logic                     rlast_q;
  logic                     fresh_q;
  logic [`DATA_WIDTH-1:0]   hold_q;
  logic                     is_wrap;
  logic                     buf_free;
  logic                     issue;

  assign is_wrap  = (burst_q == WRAP);
  assign buf_free = !rvalid_q || rready_i; // buffer empty or emptied this cycle

  assign mem.req   = (state_q == S_DATA) && buf_free && !is_wrap;
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_q[`ADDR_WIDTH-1:`BYTE_OFF_BITS];
  assign mem.wdata = '0;
  assign mem.strb  = '0;

  // WRAP beats come from the counter alone
  assign issue = (state_q == S_DATA) && buf_free && (is_wrap || mem.gnt);

  assign arready_o = (state_q == S_ADDR);
  assign rvalid_o  = rvalid_q;
  assign rlast_o   = rlast_q;
  assign rid_o     = id_q;
  assign rresp_o   = is_wrap ? SLVERR : OKAY;

  // the fresh word is passed straight through, then held in hold_q
  assign rdata_o = is_wrap ? '0 : (fresh_q ? mem.rdata : hold_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= S_ADDR;
      rvalid_q <= 1'b0;
      rlast_q  <= 1'b0;
      fresh_q  <= 1'b0;
    end else begin
      fresh_q <= mem.req && mem.gnt;
      if (issue) begin
        rvalid_q <= 1'b1;
        rlast_q  <= (req_cnt_q == len_q);
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
        rlast_q  <= 1'b0;
      end
      case (state_q)
        S_ADDR: begin
          if (arvalid_i) begin
            state_q <= S_DATA;
          end
        end
        S_DATA: begin
          if (issue && req_cnt_q == len_q) begin
            state_q <= S_DRAIN;
          end
        end
        S_DRAIN: begin
          if (rvalid_q && rready_i) begin
            state_q <= S_ADDR;
          end
        end
        default: state_q <= S_ADDR;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fresh_q) begin
      hold_q <= mem.rdata;
    end
    if (arvalid_i && arready_o) begin
      id_q      <= arid_i;
      addr_q    <= araddr_i;
      size_q    <= arsize_i;
      burst_q   <= arburst_i;
      len_q     <= arlen_i;
      req_cnt_q <= '0;
    end else if (issue) begin
      req_cnt_q <= req_cnt_q + 1'b1;
      if (burst_q != FIXED) begin
        addr_q <= addr_q + (ADDR_ONE << size_q);
      end
    end
  end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/10ps
`include "axi_mem_cfg.svh"

module mem_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  mem_port_if.arbiter              wr,
  mem_port_if.arbiter              rd,
  output logic                     ram_cs_o,
  output logic                     ram_we_o,
  output logic [`WADDR_WIDTH-1:0]  ram_addr_o,
  output logic [`DATA_WIDTH-1:0]   ram_wdata_o,
  output logic [`STRB_WIDTH-1:0]   ram_strb_o,
  input  logic [`DATA_WIDTH-1:0]   ram_rdata_i
);

  logic rd_first_q; // read engine wins the next contested cycle
  logic pick_rd;

  assign pick_rd = rd.req && (!wr.req || rd_first_q);
  assign rd.gnt  = pick_rd;
  assign wr.gnt  = wr.req && !pick_rd;

  assign ram_cs_o    = wr.req || rd.req;
  assign ram_we_o    = pick_rd ? rd.we    : wr.we;
  assign ram_addr_o  = pick_rd ? rd.addr  : wr.addr;
  assign ram_wdata_o = pick_rd ? rd.wdata : wr.wdata;
  assign ram_strb_o  = pick_rd ? rd.strb  : wr.strb;

  // the read bus is shared, only the port that read looks at it
  assign rd.rdata = ram_rdata_i;
  assign wr.rdata = ram_rdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_first_q <= 1'b0;
    end else if (wr.req && rd.req) begin
      rd_first_q <= !pick_rd; // the loser goes first next time
    end
  end

endmodule

/* design/sdram_ram.sv */
`timescale 1ns/10ps
`include "axi_mem_cfg.svh"

module sdram_ram (
  input  logic                     clk_i,
  input  logic                     cs_i,
  input  logic                     we_i,
  input  logic [`WADDR_WIDTH-1:0]  addr_i,
  input  logic [`DATA_WIDTH-1:0]   wdata_i,
  input  logic [`STRB_WIDTH-1:0]   strb_i,
  output logic [`DATA_WIDTH-1:0]   rdata_o
);

  logic [`DATA_WIDTH-1:0] mem_q [`MEM_WORDS] = '{default: '0};

  always_ff @(posedge clk_i) begin
    if (cs_i && we_i) begin
      for (int b = 0; b < `STRB_WIDTH; b++) begin
        if (strb_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end else if (cs_i) begin
      rdata_o <= mem_q[addr_i]; // holds until the next read
    end
  end

endmodule

/* design/slave_0_sdram.sv */
`timescale 1ns/10ps
`include "axi_mem_cfg.svh"

module slave_0_sdram (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // AW channel
  input  logic [`ID_BITS-1:0]      awid_i,
  input  logic [`ADDR_WIDTH-1:0]   awaddr_i,
  input  logic [`LEN_BITS-1:0]     awlen_i,
  input  logic [`SIZE_BITS-1:0]    awsize_i,
  input  axi_mem_pkg::axi_burst_t  awburst_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  // W channel
  input  logic [`DATA_WIDTH-1:0]   wdata_i,
  input  logic [`STRB_WIDTH-1:0]   wstrb_i,
  input  logic                     wlast_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  // B channel
  output logic [`ID_BITS-1:0]      bid_o,
  output axi_mem_pkg::axi_resp_t   bresp_o,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  // AR channel
  input  logic [`ID_BITS-1:0]      arid_i,
  input  logic [`ADDR_WIDTH-1:0]   araddr_i,
  input  logic [`LEN_BITS-1:0]     arlen_i,
  input  logic [`SIZE_BITS-1:0]    arsize_i,
  input  axi_mem_pkg::axi_burst_t  arburst_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  // R channel
  output logic [`ID_BITS-1:0]      rid_o,
  output logic [`DATA_WIDTH-1:0]   rdata_o,
  output axi_mem_pkg::axi_resp_t   rresp_o,
  output logic                     rlast_o,
  output logic                     rvalid_o,
  input  logic                     rready_i
);

  logic                     ram_cs;
  logic                     ram_we;
  logic [`WADDR_WIDTH-1:0]  ram_addr;
  logic [`DATA_WIDTH-1:0]   ram_wdata;
  logic [`STRB_WIDTH-1:0]   ram_strb;
  logic [`DATA_WIDTH-1:0]   ram_rdata;

  mem_port_if wr_port ();
  mem_port_if rd_port ();

  axi_write_engine u_write_engine (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .awid_i    (awid_i),
    .awaddr_i  (awaddr_i),
    .awlen_i   (awlen_i),
    .awsize_i  (awsize_i),
    .awburst_i (awburst_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wlast_i   (wlast_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bid_o     (bid_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .mem       (wr_port.requester)
  );

  axi_read_engine u_read_engine (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .arid_i    (arid_i),
    .araddr_i  (araddr_i),
    .arlen_i   (arlen_i),
    .arsize_i  (arsize_i),
    .arburst_i (arburst_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rid_o     (rid_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rlast_o   (rlast_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .mem       (rd_port.requester)
  );

  mem_arbiter u_mem_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr          (wr_port.arbiter),
    .rd          (rd_port.arbiter),
    .ram_cs_o    (ram_cs),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_strb_o  (ram_strb),
    .ram_rdata_i (ram_rdata)
  );

  sdram_ram u_sdram_ram (
    .clk_i   (clk_i),
    .cs_i    (ram_cs),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .strb_i  (ram_strb),
    .rdata_o (ram_rdata)
  );

endmodule

/* bench/slave_0_sdram_properties.sv */
`timescale 1ns/10ps
`include "axi_mem_cfg.svh"

module slave_0_sdram_properties (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic [`ID_BITS-1:0]      awid_i,
  input logic [`ADDR_WIDTH-1:0]   awaddr_i,
  input logic [`LEN_BITS-1:0]     awlen_i,
  input logic [`SIZE_BITS-1:0]    awsize_i,
  input axi_mem_pkg::axi_burst_t  awburst_i,
  input logic                     awvalid_i,
  input logic                     awready_o,
  input logic [`DATA_WIDTH-1:0]   wdata_i,
  input logic [`STRB_WIDTH-1:0]   wstrb_i,
  input logic                     wlast_i,
  input logic                     wvalid_i,
  input logic                     wready_o,
  input logic [`ID_BITS-1:0]      bid_o,
  input axi_mem_pkg::axi_resp_t   bresp_o,
  input logic                     bvalid_o,
  input logic                     bready_i,
  input logic [`ID_BITS-1:0]      arid_i,
  input logic [`ADDR_WIDTH-1:0]   araddr_i,
  input logic [`LEN_BITS-1:0]     arlen_i,
  input logic [`SIZE_BITS-1:0]    arsize_i,
  input axi_mem_pkg::axi_burst_t  arburst_i,
  input logic                     arvalid_i,
  input logic                     arready_o,
  input logic [`ID_BITS-1:0]      rid_o,
  input logic [`DATA_WIDTH-1:0]   rdata_o,
  input axi_mem_pkg::axi_resp_t   rresp_o,
  input logic                     rlast_o,
  input logic                     rvalid_o,
  input logic                     rready_i
);

  // a raised valid keeps itself and its payload until the transfer
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    awvalid_i && !awready_o |=>
      awvalid_i && $stable({awid_i, awaddr_i, awlen_i, awsize_i, awburst_i}))
    else $error("AW payload changed before awready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i && !wready_o |=> wvalid_i && $stable({wdata_i, wstrb_i, wlast_i}))
    else $error("W payload changed before wready");

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable({bid_o, bresp_o}))
    else $error("B response changed before bready");

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    arvalid_i && !arready_o |=>
      arvalid_i && $stable({arid_i, araddr_i, arlen_i, arsize_i, arburst_i}))
    else $error("AR payload changed before arready");

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable({rid_o, rdata_o, rresp_o, rlast_o}))
    else $error("R beat changed before rready");

  rlast_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i) rlast_o |-> rvalid_o)
    else $error("rlast high without rvalid");

  // both response channels come out of reset empty
  reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !bvalid_o && !rvalid_o)
    else $error("bvalid or rvalid high right after reset");

endmodule

bind slave_0_sdram slave_0_sdram_properties u_slave_0_sdram_properties (.*);

/* bench/slave_0_sdram_tb.sv */
`timescale 1ns/10ps
`include "axi_mem_cfg.svh"

module slave_0_sdram_tb;
  import axi_mem_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int NUM_RANDOM  = 20;
  localparam int NUM_FIXED   = 4;
  localparam int NUM_WRAP    = 3;
  localparam int NUM_CONC    = 20;
  localparam int NUM_BURSTS  = 2 + 2 * NUM_RANDOM + 2 * NUM_FIXED + 3 * NUM_WRAP + 2 * NUM_CONC;
  localparam int HALF_WORDS  = `MEM_WORDS / 2;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic [`ID_BITS-1:0]     awid_i;
  logic [`ADDR_WIDTH-1:0]  awaddr_i;
  logic [`LEN_BITS-1:0]    awlen_i;
  logic [`SIZE_BITS-1:0]   awsize_i;
  axi_burst_t              awburst_i;
  logic                    awvalid_i;
  logic                    awready_o;
  logic [`DATA_WIDTH-1:0]  wdata_i;
  logic [`STRB_WIDTH-1:0]  wstrb_i;
  logic                    wlast_i;
  logic                    wvalid_i;
  logic                    wready_o;
  logic [`ID_BITS-1:0]     bid_o;
  axi_resp_t               bresp_o;
  logic                    bvalid_o;
  logic                    bready_i;
  logic [`ID_BITS-1:0]     arid_i;
  logic [`ADDR_WIDTH-1:0]  araddr_i;
  logic [`LEN_BITS-1:0]    arlen_i;
  logic [`SIZE_BITS-1:0]   arsize_i;
  axi_burst_t              arburst_i;
  logic                    arvalid_i;
  logic                    arready_o;
  logic [`ID_BITS-1:0]     rid_o;
  logic [`DATA_WIDTH-1:0]  rdata_o;
  axi_resp_t               rresp_o;
  logic                    rlast_o;
  logic                    rvalid_o;
  logic                    rready_i;

  logic [7:0] model [1 << `ADDR_WIDTH]; // byte image of the RAM
  integer     seed = 12;
  string      test_name;

  slave_0_sdram u_slave_0_sdram (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // every burst gets a generous 200 cycles
  initial begin
    #(CLK_PERIOD * (10 + 200 * NUM_BURSTS));
    $display("watchdog expired, the DUT stopped completing handshakes");
    $display("Verification failed");
    $fatal(1, "timeout");
  end

  task automatic stop_on_error();
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string what, input logic [`DATA_WIDTH-1:0] exp,
                            input logic [`DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_id(input string what, input logic [`ID_BITS-1:0] exp,
                          input logic [`ID_BITS-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %b actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  // size is always 2, so an INCR beat steps one whole word
  function automatic logic [`ADDR_WIDTH-1:0] beat_addr(input logic [`ADDR_WIDTH-1:0] start,
                                                      input axi_burst_t burst, input int beat);
    if (burst == FIXED) begin
      return start;
    end
    return start + `ADDR_WIDTH'(beat * `STRB_WIDTH);
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] model_word(input logic [`ADDR_WIDTH-1:0] addr);
    logic [`DATA_WIDTH-1:0] word;
    for (int b = 0; b < `STRB_WIDTH; b++) begin
      word[8*b +: 8] = model[(int'(addr) / `STRB_WIDTH) * `STRB_WIDTH + b];
    end
    return word;
  endfunction

  function automatic void update_model(input logic [`ADDR_WIDTH-1:0] addr,
                                       input logic [`DATA_WIDTH-1:0] data,
                                       input logic [`STRB_WIDTH-1:0] strb);
    for (int b = 0; b < `STRB_WIDTH; b++) begin
      if (strb[b]) begin
        model[(int'(addr) / `STRB_WIDTH) * `STRB_WIDTH + b] = data[8*b +: 8];
      end
    end
  endfunction

  function automatic int pick_len();
    return int'($unsigned($random(seed)) % (1 << `LEN_BITS));
  endfunction

  // start word chosen so that the burst stays inside one half
  function automatic logic [`ADDR_WIDTH-1:0] pick_addr(input int half, input int len);
    int word;
    word = half * HALF_WORDS + int'($unsigned($random(seed)) % (HALF_WORDS - len));
    return `ADDR_WIDTH'(word * `STRB_WIDTH);
  endfunction

  task automatic write_burst(input logic [`ID_BITS-1:0] id, input logic [`ADDR_WIDTH-1:0] addr,
                             input int len, input axi_burst_t burst, input logic rand_strb);
    logic [`DATA_WIDTH-1:0] data;
    logic [`STRB_WIDTH-1:0] strb;
    awid_i    = id;
    awaddr_i  = addr;
    awlen_i   = `LEN_BITS'(len);
    awsize_i  = `SIZE_BITS'(2);
    awburst_i = burst;
    awvalid_i = 1'b1;
    @(negedge clk_i);
    while (!awready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
    awvalid_i = 1'b0;
    for (int i = 0; i <= len; i++) begin
      data = `DATA_WIDTH'($random(seed));
      strb = rand_strb ? `STRB_WIDTH'($random(seed)) : '1;
      wdata_i  = data;
      wstrb_i  = strb;
      wlast_i  = (i == len);
      wvalid_i = 1'b1;
      @(negedge clk_i);
      while (!wready_o) @(negedge clk_i);
      if (burst != WRAP) begin
        update_model(beat_addr(addr, burst, i), data, strb); // a WRAP beat is only drained
      end
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
    wvalid_i = 1'b0;
    wlast_i  = 1'b0;
    bready_i = 1'($random(seed));
    @(negedge clk_i);
    while (!(bvalid_o && bready_i)) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      bready_i = 1'($random(seed));
      @(negedge clk_i);
    end
    check_id("bid", id, bid_o);
    check_resp("bresp", (burst == WRAP) ? SLVERR : OKAY, bresp_o);
    @(posedge clk_i);
    #DRIVE_DELAY;
    bready_i = 1'b0;
  endtask

  task automatic read_burst(input logic [`ID_BITS-1:0] id, input logic [`ADDR_WIDTH-1:0] addr,
                            input int len, input axi_burst_t burst);
    logic [`DATA_WIDTH-1:0] exp_data;
    arid_i    = id;
    araddr_i  = addr;
    arlen_i   = `LEN_BITS'(len);
    arsize_i  = `SIZE_BITS'(2);
    arburst_i = burst;
    arvalid_i = 1'b1;
    @(negedge clk_i);
    while (!arready_o) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
    arvalid_i = 1'b0;
    for (int i = 0; i <= len; i++) begin
      rready_i = 1'($random(seed));
      @(negedge clk_i);
      while (!(rvalid_o && rready_i)) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
        rready_i = 1'($random(seed));
        @(negedge clk_i);
      end
      exp_data = (burst == WRAP) ? '0 : model_word(beat_addr(addr, burst, i));
      check_id("rid", id, rid_o);
      check_resp("rresp", (burst == WRAP) ? SLVERR : OKAY, rresp_o);
      check_data("rdata", exp_data, rdata_o);
      check_bit("rlast", i == len, rlast_o);
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
    rready_i = 1'b0;
    @(negedge clk_i);
    check_bit("rvalid after last beat", 1'b0, rvalid_o); // no beat beyond arlen+1
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  initial begin
    int                     len;
    int                     rd_len;
    int                     half;
    logic [`ID_BITS-1:0]    id;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`ADDR_WIDTH-1:0] rd_addr;
    rst_n_i   = 1'b0;
    awid_i    = '0;
    awaddr_i  = '0;
    awlen_i   = '0;
    awsize_i  = '0;
    awburst_i = INCR;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wlast_i   = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    arid_i    = '0;
    araddr_i  = '0;
    arlen_i   = '0;
    arsize_i  = '0;
    arburst_i = INCR;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    foreach (model[k]) model[k] = 8'h00; // the RAM powers up cleared
    repeat (10) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;

    test_name = "reset_state";
    @(negedge clk_i);
    check_bit("awready", 1'b1, awready_o);
    check_bit("arready", 1'b1, arready_o);
    check_bit("wready", 1'b0, wready_o);
    check_bit("bvalid", 1'b0, bvalid_o);
    check_bit("rvalid", 1'b0, rvalid_o);
    @(posedge clk_i);
    #DRIVE_DELAY;
    test_name = "single_beat";
    write_burst(`ID_BITS'(3), `ADDR_WIDTH'('h010), 0, INCR, 1'b0);
    read_burst(`ID_BITS'(5), `ADDR_WIDTH'('h010), 0, INCR);

    test_name = "incr_random";
    repeat (NUM_RANDOM) begin
      id   = `ID_BITS'($random(seed));
      len  = pick_len();
      addr = pick_addr(int'($unsigned($random(seed)) % 2), len);
      write_burst(id, addr, len, INCR, 1'b1);
      read_burst(id + 1'b1, addr, len, INCR);
    end

    test_name = "fixed_burst";
    repeat (NUM_FIXED) begin
      id   = `ID_BITS'($random(seed));
      len  = pick_len();
      addr = pick_addr(int'($unsigned($random(seed)) % 2), 0);
      write_burst(id, addr, len, FIXED, 1'b1);
      read_burst(id, addr, len, FIXED);
    end

    test_name = "wrap_burst";
    repeat (NUM_WRAP) begin
      id   = `ID_BITS'($random(seed));
      len  = pick_len();
      addr = pick_addr(int'($unsigned($random(seed)) % 2), len);
      write_burst(id, addr, len, WRAP, 1'b1);
      read_burst(id, addr, len, INCR);
      read_burst(id, addr, len, WRAP);
    end

    // writes and reads overlap, each in its own half
    test_name = "concurrent";
    for (int n = 0; n < NUM_CONC; n++) begin
      half    = n % 2;
      id      = `ID_BITS'($random(seed));
      len     = pick_len();
      rd_len  = pick_len();
      addr    = pick_addr(half, len);
      rd_addr = pick_addr(1 - half, rd_len);
      fork
        write_burst(id, addr, len, INCR, 1'b1);
        read_burst(~id, rd_addr, rd_len, INCR);
      join
    end

    $display("Verification passed");
    $finish;
  end

endmodule

/* list.f */
+incdir+design
design/axi_mem_pkg.sv
design/mem_port_if.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/mem_arbiter.sv
design/sdram_ram.sv
design/slave_0_sdram.sv
bench/slave_0_sdram_properties.sv
bench/slave_0_sdram_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/10ps \
  --top-module slave_0_sdram_tb \
  -f list.f

./obj_dir/Vslave_0_sdram_tb
